// File: sources.f
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/memctrl.sv
hdl/controller.sv
hdl/cpu.sv
tests/tb_mem.sv
tests/cpu_asserts.sv
tests/tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sources.f
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tb_cpu.sv
/* directed tests for the multicycle core; programs are built from encoders below.
   results are seen only through UART bytes, memory and the a0 debug output */
`timescale 1ns/100ps

module tb_cpu;

    logic        clk_in;
    logic        rst_n;
    logic        rdy_in;
    logic        io_buffer_full;
    logic [7:0]  mem_din;
    logic [7:0]  mem_dout;
    logic [31:0] mem_a;
    logic        mem_wr;
    logic [31:0] dbgreg_dout;

    logic [31:0] lfsr;
    logic        stall_en;
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] prog [$];
    logic [7:0]  exp_q [$];
    logic [19:0] a_hi;
    logic [19:0] b_hi;
    logic [11:0] a_lo;
    logic [11:0] b_lo;
    logic [31:0] exp_a0;

    cpu cpu_i (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .rdy_in(rdy_in),
        .mem_din(mem_din),
        .mem_dout(mem_dout),
        .mem_a(mem_a),
        .mem_wr(mem_wr),
        .io_buffer_full(io_buffer_full),
        .dbgreg_dout(dbgreg_dout)
    );

    tb_mem mem_i (
        .clk_in(clk_in),
        .addr(mem_a),
        .wdata(mem_dout),
        .wr(mem_wr),
        .rdata(mem_din)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // value left by LUI hi then ADDI lo
    function automatic logic [31:0] lui_addi(input logic [19:0] hi, input logic [11:0] lo);
        return {hi, 12'b0} + {{20{lo[11]}}, lo};
    endfunction

    task automatic check_val(input string sig, input logic [31:0] expv, input logic [31:0] got);
        if (expv !== got) begin
            $display("FAIL %0t %s expected %h got %h", $time, sig, expv, got);
            errors++;
        end
    endtask

    // UART ignores zero bytes
    task automatic expect_byte(input logic [7:0] b);
        if (b != 8'h00) begin
            exp_q.push_back(b);
        end
    endtask

    // x8 holds the I/O base in every program
    task automatic emit_uart(input logic [4:0] rs);
        prog.push_back(enc_s(12'd0, rs, 5'd8, 3'b000));
    endtask

    task automatic emit_stop();
        prog.push_back(enc_s(12'd4, 5'd0, 5'd8, 3'b000));
        prog.push_back(enc_j(21'd0, 5'd0));
    endtask

    task automatic run_program(input logic stall);
        int cycles;
        @(posedge clk_in);
        #1;
        rst_n          = 1'b0;
        rdy_in         = 1'b1;
        io_buffer_full = 1'b0;
        for (int i = 0; i < 131072; i++) begin
            mem_i.mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16));
        end
        foreach (prog[i]) begin
            for (int k = 0; k < 4; k++) begin
                mem_i.mem[4 * i + k] = prog[i][8 * k +: 8];
            end
        end
        mem_i.uart_q.delete();
        mem_i.stop_seen = 1'b0;
        repeat (2) @(posedge clk_in);
        #1;
        rst_n    = 1'b1;
        stall_en = stall;
        cycles   = 0;
        while (!mem_i.stop_seen && cycles < 40000) begin
            @(posedge clk_in);
            cycles++;
        end
        stall_en = 1'b0;
        #2;
        rdy_in         = 1'b1;
        io_buffer_full = 1'b0;
        if (!mem_i.stop_seen) begin
            $display("timeout: program never wrote the stop address");
            errors++;
        end
    endtask

    task automatic compare_uart();
        int n;
        n = (exp_q.size() < mem_i.uart_q.size()) ? exp_q.size() : mem_i.uart_q.size();
        check_val("uart_count", exp_q.size(), mem_i.uart_q.size());
        for (int i = 0; i < n; i++) begin
            check_val("uart_byte", {24'b0, exp_q[i]}, {24'b0, mem_i.uart_q[i]});
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic test_arith(input logic stall);
        int          e0;
        logic [31:0] va;
        logic [31:0] vb;
        e0 = errors;
        if (!stall) begin
            a_hi = 20'(take_bits(20));
            a_lo = 12'(take_bits(12));
            b_hi = 20'(take_bits(20));
            b_lo = 12'(take_bits(12));
        end
        va = lui_addi(a_hi, a_lo);
        vb = lui_addi(b_hi, b_lo);
        prog.delete();
        exp_q.delete();
        prog.push_back(enc_u(20'h00030, 5'd8));
        prog.push_back(enc_u(a_hi, 5'd1));
        emit_uart(5'd1);
        expect_byte(8'h00);
        prog.push_back(enc_i(a_lo, 5'd1, 3'b000, 5'd1, 7'b0010011));
        prog.push_back(enc_u(b_hi, 5'd2));
        prog.push_back(enc_i(b_lo, 5'd2, 3'b000, 5'd2, 7'b0010011));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        for (int r = 1; r <= 7; r++) begin
            emit_uart(5'(r));
        end
        expect_byte(va[7:0]);
        expect_byte(vb[7:0]);
        expect_byte(8'(va + vb));
        expect_byte(8'(va - vb));
        expect_byte(8'(va & vb));
        expect_byte(8'(va | vb));
        expect_byte(8'(va ^ vb));
        // a0 = x7
        prog.push_back(enc_r(7'h00, 5'd0, 5'd7, 3'b000, 5'd10));
        exp_a0 = va ^ vb;
        emit_stop();
        run_program(stall);
        compare_uart();
        check_val("dbgreg_dout", exp_a0, dbgreg_dout);
        finish_test(stall ? "stalls" : "arithmetic", e0);
    endtask

    task automatic test_memory();
        int          e0;
        logic [19:0] hi;
        logic [11:0] lo;
        logic [31:0] w;
        e0 = errors;
        hi = 20'(take_bits(20));
        lo = 12'(take_bits(12));
        w  = lui_addi(hi, lo);
        prog.delete();
        exp_q.delete();
        prog.push_back(enc_u(20'h00030, 5'd8));
        prog.push_back(enc_u(hi, 5'd1));
        prog.push_back(enc_i(lo, 5'd1, 3'b000, 5'd1, 7'b0010011));
        prog.push_back(enc_i(12'h400, 5'd0, 3'b000, 5'd9, 7'b0010011));
        prog.push_back(enc_s(12'd0, 5'd1, 5'd9, 3'b010));
        // byte k of the word lands in the low byte of a load at offset k
        for (int k = 0; k < 4; k++) begin
            prog.push_back(enc_i(12'(k), 5'd9, 3'b010, 5'(2 + k), 7'b0000011));
            emit_uart(5'(2 + k));
            expect_byte(w[8 * k +: 8]);
        end
        // whole word back into a0
        prog.push_back(enc_i(12'd0, 5'd9, 3'b010, 5'd10, 7'b0000011));
        emit_stop();
        run_program(1'b0);
        compare_uart();
        for (int k = 0; k < 4; k++) begin
            check_val("mem_byte", {24'b0, w[8 * k +: 8]}, {24'b0, mem_i.mem[32'h400 + k]});
        end
        check_val("dbgreg_dout", w, dbgreg_dout);
        finish_test("memory", e0);
    endtask

    task automatic test_control();
        int         e0;
        int         jal_pc;
        logic [3:0] n;
        e0 = errors;
        n  = 4'(take_bits(3)) + 4'd1;
        prog.delete();
        exp_q.delete();
        prog.push_back(enc_u(20'h00030, 5'd8));
        prog.push_back(enc_i({8'b0, n}, 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit_uart(5'd1);
        prog.push_back(enc_i(12'hfff, 5'd1, 3'b000, 5'd1, 7'b0010011));
        prog.push_back(enc_b(13'h1ff8, 5'd0, 5'd1, 3'b001));
        prog.push_back(enc_i(12'h055, 5'd0, 3'b000, 5'd2, 7'b0010011));
        prog.push_back(enc_b(13'd8, 5'd0, 5'd1, 3'b000));
        emit_uart(5'd2);
        // link lands in x11
        jal_pc = 4 * prog.size();
        prog.push_back(enc_j(21'd8, 5'd11));
        emit_uart(5'd2);
        prog.push_back(enc_i(12'h066, 5'd0, 3'b000, 5'd3, 7'b0010011));
        emit_uart(5'd3);
        emit_uart(5'd11);
        emit_stop();
        for (int i = n; i > 0; i--) begin
            expect_byte(8'(i));
        end
        expect_byte(8'h66);
        expect_byte(8'(jal_pc + 4));
        run_program(1'b0);
        compare_uart();
        finish_test("control", e0);
    endtask

    task automatic test_zero();
        int e0;
        e0 = errors;
        prog.delete();
        exp_q.delete();
        prog.push_back(enc_u(20'h00030, 5'd8));
        prog.push_back(enc_i(12'h011, 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit_uart(5'd1);
        emit_uart(5'd0);
        prog.push_back(enc_i(12'h022, 5'd0, 3'b000, 5'd2, 7'b0010011));
        emit_uart(5'd2);
        emit_stop();
        exp_q.push_back(8'h11);
        exp_q.push_back(8'h22);
        run_program(1'b0);
        compare_uart();
        finish_test("zero write", e0);
    endtask

    // random rdy_in and io_buffer_full during the stall test
    always @(posedge clk_in) begin
        #1;
        if (stall_en) begin
            rdy_in         = take_bits(1) == 32'd1;
            io_buffer_full = take_bits(1) == 32'd1;
        end
    end

    // bus rules, sampled away from the rising edge
    always @(negedge clk_in) begin
        if (rst_n && mem_wr && !rdy_in) begin
            $display("bus write seen while rdy_in was low at %0t", $time);
            errors++;
        end
        if (rst_n && mem_wr && (mem_a >= 32'h0003_0000) && io_buffer_full) begin
            $display("I/O write seen while io_buffer_full was high at %0t", $time);
            errors++;
        end
    end

    initial begin
        lfsr           = 32'h7f68e72f;
        rst_n          = 1'b0;
        rdy_in         = 1'b1;
        io_buffer_full = 1'b0;
        stall_en       = 1'b0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_arith(1'b0);
        test_memory();
        test_control();
        test_zero();
        test_arith(1'b1);
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tests/cpu_asserts.sv
/* controller protocol checks, bound into every controller instance */
`timescale 1ns/100ps

module cpu_asserts (
    input logic                     clk_in,
    input logic                     rst_n,
    input logic                     rdy_in,
    input logic                     mc_en,
    input logic                     mc_done,
    input cpu_pkg::state_e          state,
    input logic [cpu_pkg::xlen-1:0] pc,
    input logic                     rf_we
);

    // request in flight, from mc_en up to mc_done
    logic pending;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (mc_done) begin
            pending <= 1'b0;
        end else if (mc_en) begin
            pending <= 1'b1;
        end
    end

    // no second request while one is outstanding
    assert property (@(posedge clk_in) disable iff (!rst_n) pending |-> !mc_en)
        else $error("mc_en raised while a request is pending");

    // frozen core holds its FSM and PC
    assert property (@(posedge clk_in) disable iff (!rst_n)
                     !rdy_in |=> $stable(state) && $stable(pc))
        else $error("controller state moved while rdy_in low");

    // a register write is the last step of an instruction
    assert property (@(posedge clk_in) disable iff (!rst_n)
                     rf_we && rdy_in |=> state == cpu_pkg::st_fetch)
        else $error("rf_we not followed by a fetch");

endmodule

bind controller cpu_asserts cpu_asserts_i (
    .clk_in(clk_in),
    .rst_n(rst_n),
    .rdy_in(rdy_in),
    .mc_en(mc_en),
    .mc_done(mc_done),
    .state(state),
    .pc(pc),
    .rf_we(rf_we)
);

// File: tests/tb_mem.sv
/* 128 KB byte memory, read data one cycle after the address.
   UART and stop writes are captured instead of stored; I/O reads are not modeled */
`timescale 1ns/100ps

module tb_mem (
    input  logic        clk_in,
    input  logic [31:0] addr,
    input  logic [7:0]  wdata,
    input  logic        wr,
    output logic [7:0]  rdata
);

    logic [7:0] mem [0:131071];
    logic [7:0] uart_q [$];
    logic       stop_seen;

    always @(posedge clk_in) begin
        rdata <= mem[addr[16:0]];
        if (wr) begin
            if (addr == 32'h0003_0000) begin
                uart_q.push_back(wdata);
            end else if (addr == 32'h0003_0004) begin
                stop_seen = 1'b1;
            end else begin
                mem[addr[16:0]] = wdata;
            end
        end
    end

endmodule

// File: hdl/cpu.sv
/* top level of the multicycle RV32I-subset core on the byte-wide memory bus.
   mem_a only carries bits 17:0 of interest; rdy_in low freezes the core */
`timescale 1ns/100ps

module cpu (
    input  logic        clk_in,
    input  logic        rst_n,
    input  logic        rdy_in,
    input  logic [7:0]  mem_din,
    output logic [7:0]  mem_dout,
    output logic [31:0] mem_a,
    output logic        mem_wr,
    input  logic        io_buffer_full,
    output logic [31:0] dbgreg_dout
);

    // controller <-> memctrl
    logic                        mc_en;
    logic                        mc_write;
    cpu_pkg::len_e               mc_len;
    logic [cpu_pkg::xlen-1:0]    mc_addr;
    logic [cpu_pkg::xlen-1:0]    mc_wdata;
    logic                        mc_done;
    logic [cpu_pkg::xlen-1:0]    mc_rdata;

    // decode and operands
    logic [cpu_pkg::xlen-1:0]       instr;
    logic [cpu_pkg::xlen-1:0]       pc;
    cpu_pkg::op_e                   op;
    logic [cpu_pkg::reg_addr_w-1:0] rs1;
    logic [cpu_pkg::reg_addr_w-1:0] rs2;
    logic [cpu_pkg::reg_addr_w-1:0] rd;
    logic [cpu_pkg::xlen-1:0]       imm;
    logic [cpu_pkg::xlen-1:0]       rs1_data;
    logic [cpu_pkg::xlen-1:0]       rs2_data;
    logic [cpu_pkg::xlen-1:0]       alu_result;
    logic                           branch_taken;
    logic                           alu_a_sel;

    // writeback
    logic                        rf_we;
    logic [cpu_pkg::xlen-1:0]    rf_wdata;

    controller controller_i (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .rdy_in(rdy_in),
        .mc_en(mc_en),
        .mc_write(mc_write),
        .mc_len(mc_len),
        .mc_addr(mc_addr),
        .mc_wdata(mc_wdata),
        .mc_done(mc_done),
        .mc_rdata(mc_rdata),
        .instr(instr),
        .pc(pc),
        .op(op),
        .imm(imm),
        .rs2_data(rs2_data),
        .alu_result(alu_result),
        .branch_taken(branch_taken),
        .rf_we(rf_we),
        .rf_wdata(rf_wdata),
        .alu_a_sel(alu_a_sel)
    );

    memctrl memctrl_i (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .rdy_in(rdy_in),
        .mc_en(mc_en),
        .mc_write(mc_write),
        .mc_len(mc_len),
        .mc_addr(mc_addr),
        .mc_wdata(mc_wdata),
        .mc_done(mc_done),
        .mc_rdata(mc_rdata),
        .mem_din(mem_din),
        .mem_dout(mem_dout),
        .mem_a(mem_a),
        .mem_wr(mem_wr),
        .io_buffer_full(io_buffer_full)
    );

    decoder decoder_i (
        .instr(instr),
        .op(op),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .imm(imm)
    );

    regfile regfile_i (
        .clk_in(clk_in),
        .rst_n(rst_n),
        .rdy_in(rdy_in),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .we(rf_we),
        .wdata(rf_wdata),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .dbgreg_dout(dbgreg_dout)
    );

    alu alu_i (
        .op(op),
        .a(rs1_data),
        .b(rs2_data),
        .imm(imm),
        .pc(pc),
        .alu_a_sel(alu_a_sel),
        .result(alu_result),
        .branch_taken(branch_taken)
    );

endmodule

// File: hdl/controller.sv
/* one instruction at a time: fetch, exec, mem (loads/stores only), wb.
   PC updates in wb; a new memctrl request is only issued after mc_done */
`timescale 1ns/100ps

module controller (
    input  logic                     clk_in,
    input  logic                     rst_n,
    input  logic                     rdy_in,
    output logic                     mc_en,
    output logic                     mc_write,
    output cpu_pkg::len_e            mc_len,
    output logic [cpu_pkg::xlen-1:0] mc_addr,
    output logic [cpu_pkg::xlen-1:0] mc_wdata,
    input  logic                     mc_done,
    input  logic [cpu_pkg::xlen-1:0] mc_rdata,
    output logic [cpu_pkg::xlen-1:0] instr,
    output logic [cpu_pkg::xlen-1:0] pc,
    input  cpu_pkg::op_e             op,
    input  logic [cpu_pkg::xlen-1:0] imm,
    input  logic [cpu_pkg::xlen-1:0] rs2_data,
    input  logic [cpu_pkg::xlen-1:0] alu_result,
    input  logic                     branch_taken,
    output logic                     rf_we,
    output logic [cpu_pkg::xlen-1:0] rf_wdata,
    output logic                     alu_a_sel
);

    cpu_pkg::state_e          state;
    logic                     req_sent;
    logic [cpu_pkg::xlen-1:0] pc_next;
    logic [cpu_pkg::xlen-1:0] ld_data;
    logic                     is_mem;
    logic                     is_store;
    logic                     writes_rd;

    assign is_store = (op == cpu_pkg::op_sw) || (op == cpu_pkg::op_sb);
    assign is_mem   = is_store || (op == cpu_pkg::op_lw);

    // everything except stores, branches and nop writes rd
    assign writes_rd = !is_store && (op != cpu_pkg::op_beq) && (op != cpu_pkg::op_bne)
                       && (op != cpu_pkg::op_nop);

    // one request per fetch or mem phase
    assign mc_en    = rdy_in && !req_sent
                      && ((state == cpu_pkg::st_fetch) || (state == cpu_pkg::st_mem));
    assign mc_write = (state == cpu_pkg::st_mem) && is_store;
    assign mc_len   = ((state == cpu_pkg::st_mem) && (op == cpu_pkg::op_sb))
                      ? cpu_pkg::len_byte : cpu_pkg::len_word;
    assign mc_addr  = (state == cpu_pkg::st_mem) ? alu_result : pc;
    assign mc_wdata = rs2_data;

    // JAL link value comes out of the ALU as pc + 4
    assign alu_a_sel = (op == cpu_pkg::op_jal);
    assign rf_we     = (state == cpu_pkg::st_wb) && writes_rd;
    assign rf_wdata  = (op == cpu_pkg::op_lw) ? ld_data : alu_result;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state    <= cpu_pkg::st_fetch;
            req_sent <= 1'b0;
            pc       <= '0;
            instr    <= '0;
        end else if (rdy_in) begin
            case (state)
                cpu_pkg::st_fetch: begin
                    if (mc_done) begin
                        instr    <= mc_rdata;
                        req_sent <= 1'b0;
                        state    <= cpu_pkg::st_exec;
                    end else if (!req_sent) begin
                        req_sent <= 1'b1;
                    end
                end
                cpu_pkg::st_exec: begin
                    state <= is_mem ? cpu_pkg::st_mem : cpu_pkg::st_wb;
                end
                cpu_pkg::st_mem: begin
                    if (mc_done) begin
                        req_sent <= 1'b0;
                        state    <= cpu_pkg::st_wb;
                    end else if (!req_sent) begin
                        req_sent <= 1'b1;
                    end
                end
                default: begin
                    pc    <= pc_next;
                    state <= cpu_pkg::st_fetch;
                end
            endcase
        end
    end

    // next pc and load data are plain payload
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (state == cpu_pkg::st_exec) begin
                if (branch_taken || (op == cpu_pkg::op_jal)) begin
                    pc_next <= pc + imm;
                end else begin
                    pc_next <= pc + 32'd4;
                end
            end
            if ((state == cpu_pkg::st_mem) && mc_done) begin
                ld_data <= mc_rdata;
            end
        end
    end

endmodule

// File: hdl/memctrl.sv
/* byte-serial bus engine, lowest byte first; reads return data one cycle late.
   I/O writes wait on io_buffer_full, a 0x00 UART write is dropped from the bus */
`timescale 1ns/100ps

module memctrl (
    input  logic                     clk_in,
    input  logic                     rst_n,
    input  logic                     rdy_in,
    input  logic                     mc_en,
    input  logic                     mc_write,
    input  cpu_pkg::len_e            mc_len,
    input  logic [cpu_pkg::xlen-1:0] mc_addr,
    input  logic [cpu_pkg::xlen-1:0] mc_wdata,
    output logic                     mc_done,
    output logic [cpu_pkg::xlen-1:0] mc_rdata,
    input  logic [7:0]               mem_din,
    output logic [7:0]               mem_dout,
    output logic [31:0]              mem_a,
    output logic                     mem_wr,
    input  logic                     io_buffer_full
);

    logic                     busy;
    logic [2:0]               ph;
    logic [cpu_pkg::xlen-1:0] req_addr;
    logic [cpu_pkg::xlen-1:0] req_wdata;
    logic                     req_write;
    cpu_pkg::len_e            req_len;
    logic [23:0]              shift;
    logic [cpu_pkg::xlen-1:0] cycle_cnt;
    logic [2:0]               last_ph;
    logic [2:0]               issue_ph;
    logic [7:0]               wbyte;
    logic                     is_io;
    logic                     skip_zero;
    logic                     step;

    assign last_ph = (req_len == cpu_pkg::len_word) ? 3'd3 : 3'd0;
    assign is_io   = (req_addr >= cpu_pkg::io_base);

    // the only back-pressure is the UART buffer
    assign step = busy && rdy_in && !(req_write && is_io && io_buffer_full);

    assign wbyte     = 8'(req_wdata >> {ph[1:0], 3'b000});
    assign skip_zero = req_write && (req_addr == cpu_pkg::io_uart) && (wbyte == 8'h00);

    // while stalled, re-read the previous byte so mem_din is right on resume
    assign issue_ph = ((rdy_in && (ph <= last_ph)) || (ph == 3'd0)) ? ph : ph - 3'd1;

    assign mem_a    = busy ? req_addr + {29'b0, issue_ph} : '0;
    assign mem_wr   = step && req_write && !skip_zero;
    assign mem_dout = wbyte;

    // a write ends on its last byte, a read one cycle after
    assign mc_done = step && (req_write ? (ph == last_ph) : (ph == last_ph + 3'd1));

    always_comb begin
        if (req_addr == cpu_pkg::io_stop) begin
            mc_rdata = cycle_cnt;
        end else if (req_len == cpu_pkg::len_word) begin
            mc_rdata = {mem_din, shift};
        end else begin
            mc_rdata = {24'b0, mem_din};
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            ph        <= '0;
            cycle_cnt <= '0;
        end else if (rdy_in) begin
            cycle_cnt <= cycle_cnt + 32'd1;
            if (!busy) begin
                if (mc_en) begin
                    busy <= 1'b1;
                    ph   <= '0;
                end
            end else if (mc_done) begin
                busy <= 1'b0;
            end else if (step) begin
                ph <= ph + 3'd1;
            end
        end
    end

    // request latch and read assembly
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (!busy && mc_en) begin
                req_addr  <= mc_addr;
                req_wdata <= mc_wdata;
                req_write <= mc_write;
                req_len   <= mc_len;
            end
            if (step && !req_write && (ph != 3'd0) && (ph <= last_ph)) begin
                shift <= {mem_din, shift[23:8]};
            end
        end
    end

endmodule

// File: hdl/regfile.sv
/* 32 x 32 registers, combinational reads, write on the clock edge.
   x0 always reads zero; dbgreg_dout shows a0 */
`timescale 1ns/100ps

module regfile (
    input  logic                           clk_in,
    input  logic                           rst_n,
    input  logic                           rdy_in,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs1,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs2,
    input  logic [cpu_pkg::reg_addr_w-1:0] rd,
    input  logic                           we,
    input  logic [cpu_pkg::xlen-1:0]       wdata,
    output logic [cpu_pkg::xlen-1:0]       rs1_data,
    output logic [cpu_pkg::xlen-1:0]       rs2_data,
    output logic [cpu_pkg::xlen-1:0]       dbgreg_dout
);

    logic [cpu_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy_in && we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data    = regs[rs1];
    assign rs2_data    = regs[rs2];
    // a0
    assign dbgreg_dout = regs[10];

endmodule

// File: hdl/decoder.sv
/* pure combinational decode of the latched instruction word.
   unsupported opcode/funct patterns come out as op_nop */
`timescale 1ns/100ps

module decoder (
    input  logic [cpu_pkg::xlen-1:0]       instr,
    output cpu_pkg::op_e                   op,
    output logic [cpu_pkg::reg_addr_w-1:0] rs1,
    output logic [cpu_pkg::reg_addr_w-1:0] rs2,
    output logic [cpu_pkg::reg_addr_w-1:0] rd,
    output logic [cpu_pkg::xlen-1:0]       imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        op  = cpu_pkg::op_nop;
        imm = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            7'b0110111: begin
                op  = cpu_pkg::op_lui;
                imm = {instr[31:12], 12'b0};
            end
            7'b0010011: begin
                if (funct3 == 3'b000) op = cpu_pkg::op_addi;
            end
            7'b0110011: begin
                // register-register ops
                case ({funct7, funct3})
                    10'b0000000_000: op = cpu_pkg::op_add;
                    10'b0100000_000: op = cpu_pkg::op_sub;
                    10'b0000000_111: op = cpu_pkg::op_and;
                    10'b0000000_110: op = cpu_pkg::op_or;
                    10'b0000000_100: op = cpu_pkg::op_xor;
                    default:         op = cpu_pkg::op_nop;
                endcase
            end
            7'b0000011: begin
                if (funct3 == 3'b010) op = cpu_pkg::op_lw;
            end
            7'b0100011: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                if (funct3 == 3'b010) op = cpu_pkg::op_sw;
                if (funct3 == 3'b000) op = cpu_pkg::op_sb;
            end
            7'b1100011: begin
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                if (funct3 == 3'b000) op = cpu_pkg::op_beq;
                if (funct3 == 3'b001) op = cpu_pkg::op_bne;
            end
            7'b1101111: begin
                op  = cpu_pkg::op_jal;
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: op = cpu_pkg::op_nop;
        endcase
    end

endmodule

// File: hdl/alu.sv
/* combinational result and branch compare for the supported ops.
   first operand is the PC only for JAL, which yields the link address */
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::op_e             op,
    input  logic [cpu_pkg::xlen-1:0] a,
    input  logic [cpu_pkg::xlen-1:0] b,
    input  logic [cpu_pkg::xlen-1:0] imm,
    input  logic [cpu_pkg::xlen-1:0] pc,
    input  logic                     alu_a_sel,
    output logic [cpu_pkg::xlen-1:0] result,
    output logic                     branch_taken
);

    logic [cpu_pkg::xlen-1:0] op_a;
    logic [cpu_pkg::xlen-1:0] op_b;

    assign op_a = alu_a_sel ? pc : a;

    always_comb begin
        case (op)
            cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
            cpu_pkg::op_xor, cpu_pkg::op_beq, cpu_pkg::op_bne: op_b = b;
            cpu_pkg::op_jal:                                   op_b = 32'd4;
            default:                                           op_b = imm;
        endcase
    end

    always_comb begin
        case (op)
            cpu_pkg::op_lui: result = imm;
            cpu_pkg::op_sub: result = op_a - op_b;
            cpu_pkg::op_and: result = op_a & op_b;
            cpu_pkg::op_or:  result = op_a | op_b;
            cpu_pkg::op_xor: result = op_a ^ op_b;
            cpu_pkg::op_nop: result = '0;
            // addi, add, load/store address, link
            default:         result = op_a + op_b;
        endcase
    end

    assign branch_taken = ((op == cpu_pkg::op_beq) && (op_a == op_b))
                          || ((op == cpu_pkg::op_bne) && (op_a != op_b));

endmodule

// File: hdl/cpu_pkg.sv
/* shared widths, encodings and I/O map for the multicycle core.
   I/O space starts at 0x30000; only the RV32I subset in op_e is executed */
package cpu_pkg;

    localparam int unsigned xlen = 32;
    localparam int unsigned reg_addr_w = 5;

    // memory-mapped I/O
    localparam logic [xlen-1:0] io_base = 32'h0003_0000;
    localparam logic [xlen-1:0] io_uart = 32'h0003_0000;
    localparam logic [xlen-1:0] io_stop = 32'h0003_0004;

    // supported operations, anything else decodes to op_nop
    typedef enum logic [3:0] {
        op_lui,
        op_addi,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_lw,
        op_sw,
        op_sb,
        op_beq,
        op_bne,
        op_jal,
        op_nop
    } op_e;

    typedef enum logic {
        len_byte,
        len_word
    } len_e;

    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_mem,
        st_wb
    } state_e;

endpackage
